// ==== dv/crtc_ref.svh ====
/* CRTC testbench reference
   Register reset image, pi read model and a raster model stepped once
   per character strobe from the shadow register values */
`ifndef CRTC_REF_SVH
`define CRTC_REF_SVH

typedef struct packed {
    logic [7:0]  col;               // Character column
    logic        h_de;              // Horizontal display flag
    logic        hs;
    logic [3:0]  hs_cnt;            // Strobes spent in h_sync
    logic [4:0]  ra;
    logic [6:0]  row;
    logic        adj;               // In the extra scan lines
    logic [4:0]  adj_cnt;
    logic        v_de;
    logic        vs;
    logic [3:0]  vs_cnt;            // Rows spent in v_sync
    logic [13:0] row_start;         // MA of the first character in the row
    logic [13:0] ma;
    logic        sof;               // Frame started on this strobe
} raster_t;

// PET 60 Hz values, everything else clears
function automatic logic [7:0] reset_value(input int idx);
    case (idx)
        0:       return 8'd63;
        1:       return 8'd40;
        2:       return 8'd48;
        3:       return 8'h15;
        4:       return 8'd32;
        6:       return 8'd25;
        7:       return 8'd28;
        9:       return 8'd7;
        12:      return 8'h10;
        default: return 8'h00;
    endcase
endfunction

// Low address nibble picks the register
function automatic logic [7:0] pi_expect(input logic [7:0] rg [18], input logic [15:0] addr);
    return rg[addr[3:0]];
endfunction

function automatic raster_t raster_reset(input logic [13:0] start);
    raster_t s;
    s           = '0;
    s.h_de      = 1'b1;             // Both flags start high
    s.v_de      = 1'b1;
    s.row_start = start;
    return s;
endfunction

// One character strobe
function automatic raster_t raster_step(input raster_t s, input logic [7:0] rg [18],
                                        input logic [13:0] start);
    raster_t    n;
    logic       wrap;
    logic       ra_last;
    logic       row_next;
    logic       new_frame;
    logic [3:0] hsw;
    logic [3:0] vsw;
    n         = s;
    n.sof     = 1'b0;
    hsw       = rg[3][3:0];         // R3 low nibble
    vsw       = rg[3][7:4];         // R3 high nibble
    wrap      = s.col >= rg[0];
    n.col     = wrap ? 8'd0 : s.col + 8'd1;
    if (n.col == rg[1]) n.h_de = 1'b0;
    else if (wrap) n.h_de = 1'b1;
    if (s.hs) begin
        n.hs_cnt = s.hs_cnt + 4'd1;
        if (s.hs_cnt >= hsw) begin  // Pulse has lasted hsw strobes
            n.hs     = 1'b0;
            n.hs_cnt = '0;
        end
    end else if (n.col == rg[2] && hsw != 4'd0) begin
        n.hs     = 1'b1;
        n.hs_cnt = 4'd1;
    end
    n.ma = s.ma + 14'd1;
    if (wrap) begin
        ra_last   = s.ra >= rg[9][4:0];
        n.ra      = ra_last ? 5'd0 : s.ra + 5'd1;
        row_next  = 1'b0;
        new_frame = 1'b0;
        if (s.adj) begin            // Extra scan lines count down to frame end
            n.adj_cnt = s.adj_cnt + 5'd1;
            if (s.adj_cnt + 5'd1 >= rg[5][4:0]) begin
                new_frame = 1'b1;
                row_next  = 1'b1;
            end
        end else if (ra_last) begin
            row_next = 1'b1;
            if (s.row >= rg[4][6:0]) begin
                if (rg[5][4:0] != 5'd0) begin
                    n.adj     = 1'b1;
                    n.adj_cnt = '0;
                    row_next  = 1'b0;   // Row holds through the extra lines
                end else begin
                    new_frame = 1'b1;
                end
            end
        end
        if (new_frame) begin
            n.row       = '0;
            n.row_start = start;
            n.adj       = 1'b0;
            n.adj_cnt   = '0;
            n.sof       = 1'b1;
        end else if (row_next) begin
            n.row       = s.row + 7'd1;
            n.row_start = s.row_start + rg[1];
        end
        if (row_next) begin
            if (n.row == rg[6][6:0]) n.v_de = 1'b0;
            else if (new_frame) n.v_de = 1'b1;
            if (s.vs) begin
                n.vs_cnt = s.vs_cnt + 4'd1;
                if (s.vs_cnt >= vsw) begin
                    n.vs     = 1'b0;
                    n.vs_cnt = '0;
                end
            end else if (n.row == rg[7][6:0] && vsw != 4'd0) begin
                n.vs     = 1'b1;
                n.vs_cnt = 4'd1;
            end
        end
        n.ma = n.row_start;         // Every line restarts at the row start
    end
    return n;
endfunction

function automatic crtc_pkg::crtc_video_t raster_video(input raster_t s);
    crtc_pkg::crtc_video_t v;
    v.display_enable = s.h_de && s.v_de;
    v.h_sync         = s.hs;
    v.v_sync         = s.vs;
    v.ma             = s.ma;
    v.ra             = s.ra;
    return v;
endfunction

`endif

// ==== dv/crtc_tb.sv ====
/* CRTC testbench
   Reset image, CPU write and pi read back, window decode, and the
   horizontal and vertical raster checked against a reference model */
`include "crtc_defs.svh"

module crtc_tb;
    localparam int CLK_PERIOD      = 10;
    localparam int STROBE_BUDGET   = 20 + 80 + 10 + 80 + 400;  // Per test, 1 to 5
    localparam int WATCHDOG_CYCLES = STROBE_BUDGET * 2 + 200;  // Two cycles per strobe

    logic                    pi_read;
    logic                    reset;
    logic                    crtc_select_i;
    logic                    cpu_we_i;
    crtc_pkg::crtc_cpu_bus_t cpu_bus_i;
    logic [15:0]             pi_addr_i;
    logic                    pi_rd_i;
    logic [7:0]              pi_data_o;
    logic                    pi_data_oe_o;
    logic [4:0]              crtc_addr_o;
    logic [7:0]              crtc_r_o;
    logic                    cclk_en_i;
    logic [13:0]             screen_addr_i;
    crtc_pkg::crtc_video_t   video_o;

    `include "crtc_ref.svh"

    logic [7:0]            shadow [`CRTC_NUM_REGS];    // Registers as written
    logic [4:0]            addr_shadow;
    raster_t               model;
    crtc_pkg::crtc_video_t exp_video;
    logic                  model_on;                   // Compare video_o
    logic                  stepped;
    int                    strobes;
    int                    frames;
    int                    errors;
    int                    pass_count;
    int                    fail_count;
    int                    i;
    string                 test_name;
    logic [4:0]            idx;
    logic [7:0]            val;

    crtc_top dut0 (
        .pi_read       (pi_read),
        .reset         (reset),
        .crtc_select_i (crtc_select_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_bus_i     (cpu_bus_i),
        .pi_addr_i     (pi_addr_i),
        .pi_rd_i       (pi_rd_i),
        .pi_data_o     (pi_data_o),
        .pi_data_oe_o  (pi_data_oe_o),
        .crtc_addr_o   (crtc_addr_o),
        .crtc_r_o      (crtc_r_o),
        .cclk_en_i     (cclk_en_i),
        .screen_addr_i (screen_addr_i),
        .video_o       (video_o)
    );

    initial begin
        pi_read = 1'b0;
        forever #(CLK_PERIOD / 2) pi_read = ~pi_read;
    end

    // Character strobe on every second cycle
    initial begin
        cclk_en_i = 1'b0;
        forever begin
            @(posedge pi_read);
            #1 cclk_en_i = ~cclk_en_i;
        end
    end

    // Model steps on the same edge as the DUT, compared once outputs settle
    always @(posedge pi_read) begin
        stepped = 1'b0;
        if (reset) begin
            model = raster_reset(screen_addr_i);
        end else if (cclk_en_i) begin
            model   = raster_step(model, shadow, screen_addr_i);
            stepped = 1'b1;
        end
        @(negedge pi_read);
        if (stepped && model_on) begin
            exp_video = raster_video(model);
            strobes++;
            if (model.sof) frames++;
            assert (video_o == exp_video) else begin
                $display("mismatch %s strobe %0d: video expected %h actual %h",
                         test_name, strobes, exp_video, video_o);
                errors++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(posedge pi_read);
        #1 reset = 1'b0;
        for (int k = 0; k < `CRTC_NUM_REGS; k++) shadow[k] = reset_value(k);
        addr_shadow = '0;
    endtask

    // One CPU bus write, shadow follows once the edge has taken it
    task automatic cpu_write(input logic rs, input logic [7:0] data);
        crtc_select_i  = 1'b1;
        cpu_we_i       = 1'b1;
        cpu_bus_i.rs   = rs;
        cpu_bus_i.data = data;
        @(posedge pi_read);
        #1;
        crtc_select_i = 1'b0;
        cpu_we_i      = 1'b0;
        if (!rs) addr_shadow = data[4:0];
        else if (addr_shadow < `CRTC_NUM_REGS) shadow[addr_shadow] = data;
    endtask

    task automatic reg_write(input logic [4:0] index, input logic [7:0] data);
        cpu_write(1'b0, {3'd0, index});
        cpu_write(1'b1, data);
    endtask

    task automatic window_read(input logic [15:0] addr, input logic [7:0] expected);
        pi_addr_i = addr;
        pi_rd_i   = 1'b1;
        @(posedge pi_read);
        #1 pi_rd_i = 1'b0;
        assert (pi_data_oe_o) else begin
            $display("%s: output enable low inside the window at %h", test_name, addr);
            errors++;
        end
        assert (pi_data_o == expected) else begin
            $display("mismatch %s: read %h expected %h actual %h",
                     test_name, addr, expected, pi_data_o);
            errors++;
        end
    endtask

    // Read strobe outside the window must not touch pi_data_o
    task automatic outside_read(input logic [15:0] addr, input logic [7:0] expected);
        pi_addr_i = addr;
        pi_rd_i   = 1'b1;
        @(posedge pi_read);
        #1 pi_rd_i = 1'b0;
        assert (!pi_data_oe_o) else begin
            $display("%s: output enable high outside the window at %h", test_name, addr);
            errors++;
        end
        assert (pi_data_o == expected) else begin
            $display("mismatch %s: read %h expected %h actual %h",
                     test_name, addr, expected, pi_data_o);
            errors++;
        end
    endtask

    task automatic wait_strobes(input int n);
        int stop_at;
        stop_at = strobes + n;
        while (strobes < stop_at) begin
            @(posedge pi_read);
            #1;
        end
    endtask

    task automatic wait_frames(input int n);
        int stop_at;
        stop_at = frames + n;
        while (frames < stop_at) begin
            @(posedge pi_read);
            #1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors    = 0;
    endtask

    task automatic end_test();
        $display("test %s: %s, %0d errors", test_name, errors == 0 ? "passed" : "failed", errors);
        if (errors == 0) pass_count++;
        else fail_count++;
    endtask

    initial begin
        void'($urandom(4));
        reset         = 1'b1;
        crtc_select_i = 1'b0;
        cpu_we_i      = 1'b0;
        cpu_bus_i     = '0;
        pi_addr_i     = 16'h0000;
        pi_rd_i       = 1'b0;
        screen_addr_i = 14'h0100;
        model_on      = 1'b0;
        strobes       = 0;
        frames        = 0;
        pass_count    = 0;
        fail_count    = 0;
        test_name     = "setup";
        apply_reset();

        begin_test("reset_image");
        for (i = 0; i < 16; i++) window_read(16'(`CRTC_PI_BASE + i), reset_value(i));
        end_test();

        begin_test("write_readback");
        for (i = 0; i < 24; i++) begin
            idx = (i % 4 == 3) ? 5'($urandom_range(31, 18)) : 5'($urandom_range(17, 0));
            val = 8'($urandom);
            cpu_write(1'b0, {3'($urandom), idx});      // Upper bits must be dropped
            assert (crtc_addr_o == idx) else begin
                $display("mismatch %s: address expected %0d actual %0d",
                         test_name, idx, crtc_addr_o);
                errors++;
            end
            cpu_write(1'b1, val);
            if (idx < `CRTC_NUM_REGS) begin
                assert (crtc_r_o == val) else begin
                    $display("mismatch %s: R%0d expected %h actual %h",
                             test_name, idx, val, crtc_r_o);
                    errors++;
                end
            end
        end
        for (i = 0; i < 16; i++) begin
            window_read(16'(`CRTC_PI_BASE + i), pi_expect(shadow, 16'(`CRTC_PI_BASE + i)));
        end
        for (i = 16; i < `CRTC_NUM_REGS; i++) begin    // Beyond the pi window
            cpu_write(1'b0, 8'(i));
            assert (crtc_r_o == shadow[i]) else begin
                $display("mismatch %s: R%0d expected %h actual %h",
                         test_name, i, shadow[i], crtc_r_o);
                errors++;
            end
        end
        end_test();

        begin_test("window_decode");
        // R1 differs from R15 and R0, what a stray read at E8EF or E900 would load
        val = 8'h01;
        while (val == shadow[0] || val == shadow[15]) val++;
        reg_write(`CRTC_R1_H_DISPLAYED, val);
        window_read(16'(`CRTC_PI_BASE + 1), val);
        outside_read(16'hE8EF, val);
        outside_read(16'hE900, val);
        pi_addr_i = 16'h0000;
        end_test();

        begin_test("h_timing");
        model_on = 1'b1;
        apply_reset();
        reg_write(`CRTC_R0_H_TOTAL, 8'd9);
        reg_write(`CRTC_R1_H_DISPLAYED, 8'd6);
        reg_write(`CRTC_R2_H_SYNC_POS, 8'd7);
        reg_write(`CRTC_R3_SYNC_WIDTH, 8'h22);         // Two chars h_sync, two rows v_sync
        wait_strobes(60);
        end_test();

        begin_test("v_timing");
        screen_addr_i = 14'h0340;
        reg_write(`CRTC_R9_SCAN_LINE, 8'd1);
        reg_write(`CRTC_R4_V_TOTAL, 8'd3);
        reg_write(`CRTC_R6_V_DISPLAYED, 8'd2);
        reg_write(`CRTC_R7_V_SYNC_POS, 8'd2);
        reg_write(`CRTC_R5_V_LINE_ADJUST, 8'd1);
        reg_write(`CRTC_R3_SYNC_WIDTH, 8'h12);         // One row v_sync, h_sync stays two chars
        wait_frames(3);                                 // First one may be partial
        model_on = 1'b0;
        end_test();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/crtc_defs.svh ====
/* CRTC register map
   Register indices, PET 60 Hz reset image and the pi read window */
`ifndef CRTC_DEFS_SVH
`define CRTC_DEFS_SVH

`define CRTC_NUM_REGS           18      // R0..R17

`define CRTC_R0_H_TOTAL         0       // Characters per line, minus one
`define CRTC_R1_H_DISPLAYED     1
`define CRTC_R2_H_SYNC_POS      2
`define CRTC_R3_SYNC_WIDTH      3       // [7:4] vsync rows, [3:0] hsync chars
`define CRTC_R4_V_TOTAL         4
`define CRTC_R5_V_LINE_ADJUST   5
`define CRTC_R6_V_DISPLAYED     6
`define CRTC_R7_V_SYNC_POS      7
`define CRTC_R9_SCAN_LINE       9       // Scan lines per row, minus one

// Reset image, non-CRTC PET timing
`define CRTC_RST_R0             8'd63
`define CRTC_RST_R1             8'd40
`define CRTC_RST_R2             8'd48
`define CRTC_RST_R3             8'h15
`define CRTC_RST_R4             8'd32
`define CRTC_RST_R5             8'd0
`define CRTC_RST_R6             8'd25
`define CRTC_RST_R7             8'd28
`define CRTC_RST_R8             8'd0
`define CRTC_RST_R9             8'd7
`define CRTC_RST_R10            8'd0
`define CRTC_RST_R11            8'd0
`define CRTC_RST_R12            8'h10   // Display start high byte
`define CRTC_RST_R13            8'd0
`define CRTC_RST_R14            8'd0
`define CRTC_RST_R15            8'd0
`define CRTC_RST_R16            8'd0

`define CRTC_PI_BASE            16'hE8F0    // 16-byte read window

`endif

// ==== hdl/crtc_pkg.sv ====
/* CRTC types
   Timing fields, R3 sync width views, CPU bus and video output bundles */
package crtc_pkg;

    // R3 holds both sync widths in one byte
    typedef union packed {
        logic [7:0] raw;                // As written by the CPU
        struct packed {
            logic [3:0] v_width;        // Vertical sync, rows
            logic [3:0] h_width;        // Horizontal sync, character clocks
        } width;
    } crtc_sync_width_u;

    // Everything the sync generator reads from the register file
    typedef struct packed {
        logic [7:0] h_total;            // Characters per line, minus one
        logic [7:0] h_displayed;
        logic [7:0] h_sync_pos;
        logic [3:0] h_sync_width;
        logic [6:0] v_total;            // Rows per frame, minus one
        logic [4:0] v_line_adjust;      // Extra scan lines at frame end
        logic [6:0] v_displayed;
        logic [6:0] v_sync_pos;
        logic [3:0] v_sync_width;
        logic [4:0] char_height;        // Scan lines per row, minus one
    } crtc_timing_t;

    // CPU side write bus
    typedef struct packed {
        logic       rs;                 // Bus address bit 0
        logic [7:0] data;
    } crtc_cpu_bus_t;

    // Video timing outputs
    typedef struct packed {
        logic        display_enable;
        logic        h_sync;
        logic        v_sync;
        logic [13:0] ma;                // Refresh address
        logic [4:0]  ra;                // Raster address
    } crtc_video_t;

endpackage

// ==== hdl/crtc_regs.sv ====
/* CRTC register file
   CPU writes through address/data pair, pi host reads through a 16-byte
   window, timing fields decoded for the sync generator */
`include "crtc_defs.svh"

module crtc_regs (
    input  logic                    pi_read,
    input  logic                    reset,

    input  logic                    crtc_select_i,  // CPU address in CRTC range
    input  logic                    cpu_we_i,
    input  crtc_pkg::crtc_cpu_bus_t cpu_bus_i,

    input  logic [15:0]             pi_addr_i,
    input  logic                    pi_rd_i,
    output logic [7:0]              pi_data_o,
    output logic                    pi_data_oe_o,

    output logic [4:0]              crtc_addr_o,    // Selected register index
    output logic [7:0]              crtc_r_o,       // Contents of selected register
    output crtc_pkg::crtc_timing_t  timing_o
);
    logic [7:0] r [`CRTC_NUM_REGS];     // R0..R17

    logic cpu_wr;
    logic addr_wr;
    logic reg_wr;
    logic addr_valid;
    logic pi_hit;
    crtc_pkg::crtc_sync_width_u r3_view;

    // CPU write decode, rs picks address or data register
    assign cpu_wr     = crtc_select_i && cpu_we_i;
    assign addr_wr    = cpu_wr && !cpu_bus_i.rs;
    assign reg_wr     = cpu_wr && cpu_bus_i.rs;
    assign addr_valid = crtc_addr_o < 5'(`CRTC_NUM_REGS);   // R18..R31 do not exist

    always_ff @(posedge pi_read) begin
        if (reset) begin
            crtc_addr_o                   <= '0;
            r[`CRTC_R0_H_TOTAL]           <= `CRTC_RST_R0;
            r[`CRTC_R1_H_DISPLAYED]       <= `CRTC_RST_R1;
            r[`CRTC_R2_H_SYNC_POS]        <= `CRTC_RST_R2;
            r[`CRTC_R3_SYNC_WIDTH]        <= `CRTC_RST_R3;
            r[`CRTC_R4_V_TOTAL]           <= `CRTC_RST_R4;
            r[`CRTC_R5_V_LINE_ADJUST]     <= `CRTC_RST_R5;
            r[`CRTC_R6_V_DISPLAYED]       <= `CRTC_RST_R6;
            r[`CRTC_R7_V_SYNC_POS]        <= `CRTC_RST_R7;
            r[8]                          <= `CRTC_RST_R8;
            r[`CRTC_R9_SCAN_LINE]         <= `CRTC_RST_R9;
            r[10]                         <= `CRTC_RST_R10;
            r[11]                         <= `CRTC_RST_R11;
            r[12]                         <= `CRTC_RST_R12;
            r[13]                         <= `CRTC_RST_R13;
            r[14]                         <= `CRTC_RST_R14;
            r[15]                         <= `CRTC_RST_R15;
            r[16]                         <= `CRTC_RST_R16;
            r[17]                         <= 8'h00;
        end else begin
            if (addr_wr) begin
                crtc_addr_o <= cpu_bus_i.data[4:0];     // Upper bits dropped
            end
            if (reg_wr && addr_valid) begin
                r[crtc_addr_o] <= cpu_bus_i.data;
            end
        end
    end

    // Read back of the selected register, zero outside R0..R17
    assign crtc_r_o = addr_valid ? r[crtc_addr_o] : 8'h00;

    // Pi window decode
    assign pi_hit = (pi_addr_i >= `CRTC_PI_BASE) &&
                    (pi_addr_i <= `CRTC_PI_BASE + 16'd15);
    assign pi_data_oe_o = pi_hit;

    // Data captured on the read strobe, held until the next window read
    always_ff @(posedge pi_read) begin
        if (reset) begin
            pi_data_o <= '0;
        end else if (pi_rd_i && pi_hit) begin
            pi_data_o <= r[pi_addr_i[3:0]];     // Window covers R0..R15
        end
    end

    // R3 carries both sync widths
    assign r3_view.raw = r[`CRTC_R3_SYNC_WIDTH];

    always_comb begin
        timing_o.h_total       = r[`CRTC_R0_H_TOTAL];
        timing_o.h_displayed   = r[`CRTC_R1_H_DISPLAYED];
        timing_o.h_sync_pos    = r[`CRTC_R2_H_SYNC_POS];
        timing_o.h_sync_width  = r3_view.width.h_width;
        timing_o.v_total       = r[`CRTC_R4_V_TOTAL][6:0];
        timing_o.v_line_adjust = r[`CRTC_R5_V_LINE_ADJUST][4:0];
        timing_o.v_displayed   = r[`CRTC_R6_V_DISPLAYED][6:0];
        timing_o.v_sync_pos    = r[`CRTC_R7_V_SYNC_POS][6:0];
        timing_o.v_sync_width  = r3_view.width.v_width;
        timing_o.char_height   = r[`CRTC_R9_SCAN_LINE][4:0];
    end

    // Address register takes the low five data bits on the next edge
    a_addr_load: assert property (@(posedge pi_read) disable iff (reset)
        addr_wr |=> crtc_addr_o == $past(cpu_bus_i.data[4:0]));

    // Data writes to a nonexistent register change no timing field
    a_no_oob_write: assert property (@(posedge pi_read) disable iff (reset)
        reg_wr && !addr_valid |=> $stable(timing_o));

endmodule

// ==== hdl/crtc_sync_gen.sv ====
/* CRTC sync generator
   Column, scan line and row counters giving display enable, syncs,
   refresh address and raster address, one step per character strobe */
module crtc_sync_gen (
    input  logic                    pi_read,
    input  logic                    reset,
    input  logic                    cclk_en_i,          // Character clock strobe
    input  logic [13:0]             screen_addr_i,      // Display start address
    input  crtc_pkg::crtc_timing_t  timing_i,
    output crtc_pkg::crtc_video_t   video_o
);
    // Horizontal chain
    logic [7:0]  h_col_q, h_col_d;
    logic        line_end;                  // Last column of the line
    logic        h_display_q, h_display_d;
    logic        h_sync_q, h_sync_d;
    logic [3:0]  h_sync_ctr_q, h_sync_ctr_d;

    // Vertical chain
    logic [4:0]  ra_q, ra_d;
    logic [6:0]  row_q, row_d;
    logic        in_adj_q, in_adj_d;        // In the extra scan lines after v_total
    logic [4:0]  adj_ctr_q, adj_ctr_d;
    logic        v_display_q, v_display_d;
    logic        v_sync_q, v_sync_d;
    logic [3:0]  v_sync_ctr_q, v_sync_ctr_d;
    logic        ra_wrap;
    logic        row_end;
    logic        last_row;
    logic        adj_end;
    logic        adj_start;
    logic        frame_start;
    logic        row_step;

    // Addressing
    logic [13:0] row_addr_q, row_addr_d;    // MA at the start of the current row
    logic [13:0] ma_q, ma_d;

    // Out of range totals wrap as well, so a shrunken frame recovers at once
    assign line_end = h_col_q >= timing_i.h_total;

    always_comb begin
        h_col_d = line_end ? 8'd0 : h_col_q + 8'd1;

        // Display flag drops at h_displayed, returns at the wrap
        h_display_d = h_display_q;
        if (h_col_d == timing_i.h_displayed) h_display_d = 1'b0;
        else if (line_end) h_display_d = 1'b1;

        h_sync_d     = h_sync_q;
        h_sync_ctr_d = h_sync_ctr_q;
        if (h_sync_q) begin
            if (h_sync_ctr_q >= timing_i.h_sync_width) begin    // Width reached
                h_sync_d     = 1'b0;
                h_sync_ctr_d = '0;
            end else begin
                h_sync_ctr_d = h_sync_ctr_q + 4'd1;
            end
        end else if (h_col_d == timing_i.h_sync_pos && timing_i.h_sync_width != '0) begin
            h_sync_d     = 1'b1;
            h_sync_ctr_d = 4'd1;                // First strobe of the pulse
        end
    end

    // Row and frame events, all qualified by the line wrap
    assign ra_wrap     = ra_q >= timing_i.char_height;
    assign row_end     = line_end && ra_wrap && !in_adj_q;
    assign last_row    = row_q >= timing_i.v_total;
    assign adj_end     = line_end && in_adj_q &&
                         (adj_ctr_q + 5'd1 >= timing_i.v_line_adjust);
    assign adj_start   = row_end && last_row && timing_i.v_line_adjust != '0;
    assign frame_start = (row_end && last_row && timing_i.v_line_adjust == '0) || adj_end;
    assign row_step    = (row_end && !adj_start) || adj_end;

    always_comb begin
        // RA runs every line, adjust lines included
        ra_d = ra_q;
        if (line_end) ra_d = ra_wrap ? 5'd0 : ra_q + 5'd1;

        in_adj_d  = in_adj_q;
        adj_ctr_d = adj_ctr_q;
        if (adj_start) begin
            in_adj_d  = 1'b1;
            adj_ctr_d = '0;
        end else if (frame_start) begin
            in_adj_d  = 1'b0;
            adj_ctr_d = '0;
        end else if (line_end && in_adj_q) begin
            adj_ctr_d = adj_ctr_q + 5'd1;
        end

        row_d      = row_q;
        row_addr_d = row_addr_q;
        if (frame_start) begin
            row_d      = '0;
            row_addr_d = screen_addr_i;         // New frame picks up the start address
        end else if (row_step) begin
            row_d      = row_q + 7'd1;
            row_addr_d = row_addr_q + {6'd0, timing_i.h_displayed};
        end

        // Vertical flags evaluated per row, same rules as horizontal
        v_display_d  = v_display_q;
        v_sync_d     = v_sync_q;
        v_sync_ctr_d = v_sync_ctr_q;
        if (row_step) begin
            if (row_d == timing_i.v_displayed) v_display_d = 1'b0;
            else if (frame_start) v_display_d = 1'b1;

            if (v_sync_q) begin
                if (v_sync_ctr_q >= timing_i.v_sync_width) begin
                    v_sync_d     = 1'b0;
                    v_sync_ctr_d = '0;
                end else begin
                    v_sync_ctr_d = v_sync_ctr_q + 4'd1;
                end
            end else if (row_d == timing_i.v_sync_pos && timing_i.v_sync_width != '0) begin
                v_sync_d     = 1'b1;
                v_sync_ctr_d = 4'd1;
            end
        end

        ma_d = line_end ? row_addr_d : ma_q + 14'd1;    // Reload at each line start
    end

    always_ff @(posedge pi_read) begin
        if (reset) begin
            h_col_q      <= '0;
            h_display_q  <= 1'b1;
            h_sync_q     <= 1'b0;
            h_sync_ctr_q <= '0;
            ra_q         <= '0;
            row_q        <= '0;
            in_adj_q     <= 1'b0;
            adj_ctr_q    <= '0;
            v_display_q  <= 1'b1;
            v_sync_q     <= 1'b0;
            v_sync_ctr_q <= '0;
            row_addr_q   <= screen_addr_i;
            ma_q         <= '0;
        end else if (cclk_en_i) begin           // Everything holds between strobes
            h_col_q      <= h_col_d;
            h_display_q  <= h_display_d;
            h_sync_q     <= h_sync_d;
            h_sync_ctr_q <= h_sync_ctr_d;
            ra_q         <= ra_d;
            row_q        <= row_d;
            in_adj_q     <= in_adj_d;
            adj_ctr_q    <= adj_ctr_d;
            v_display_q  <= v_display_d;
            v_sync_q     <= v_sync_d;
            v_sync_ctr_q <= v_sync_ctr_d;
            row_addr_q   <= row_addr_d;
            ma_q         <= ma_d;
        end
    end

    assign video_o.display_enable = h_display_q && v_display_q;
    assign video_o.h_sync         = h_sync_q;
    assign video_o.v_sync         = v_sync_q;
    assign video_o.ma             = ma_q;
    assign video_o.ra             = ra_q;

    // After a line wrap RA sits within the char height that was in force
    a_ra_range: assert property (@(posedge pi_read) disable iff (reset)
        cclk_en_i && line_end |=> ra_q <= $past(timing_i.char_height));

    // Horizontal sync pulse is at most 15 character clocks wide
    a_hsync_width: assert property (@(posedge pi_read) disable iff (reset)
        $rose(h_sync_q) |-> not (h_sync_q throughout cclk_en_i [->16]));

endmodule

// ==== hdl/crtc_top.sv ====
/* CRTC top level
   Register file feeding the sync generator */
module crtc_top (
    input  logic                    pi_read,        // System clock
    input  logic                    reset,

    // CPU write port
    input  logic                    crtc_select_i,
    input  logic                    cpu_we_i,
    input  crtc_pkg::crtc_cpu_bus_t cpu_bus_i,

    // Pi read port
    input  logic [15:0]             pi_addr_i,
    input  logic                    pi_rd_i,
    output logic [7:0]              pi_data_o,
    output logic                    pi_data_oe_o,

    // Register visibility for test
    output logic [4:0]              crtc_addr_o,
    output logic [7:0]              crtc_r_o,

    // Video timing
    input  logic                    cclk_en_i,      // Character clock strobe
    input  logic [13:0]             screen_addr_i,
    output crtc_pkg::crtc_video_t   video_o
);
    crtc_pkg::crtc_timing_t timing;     // Decoded R0..R9 fields

    crtc_regs regs0 (
        .pi_read       (pi_read),
        .reset         (reset),
        .crtc_select_i (crtc_select_i),
        .cpu_we_i      (cpu_we_i),
        .cpu_bus_i     (cpu_bus_i),
        .pi_addr_i     (pi_addr_i),
        .pi_rd_i       (pi_rd_i),
        .pi_data_o     (pi_data_o),
        .pi_data_oe_o  (pi_data_oe_o),
        .crtc_addr_o   (crtc_addr_o),
        .crtc_r_o      (crtc_r_o),
        .timing_o      (timing)
    );

    // Start address comes straight from the top, R12/R13 are not used here
    crtc_sync_gen sync0 (
        .pi_read       (pi_read),
        .reset         (reset),
        .cclk_en_i     (cclk_en_i),
        .screen_addr_i (screen_addr_i),
        .timing_i      (timing),
        .video_o       (video_o)
    );

endmodule

// ==== tb.f ====
+incdir+hdl
+incdir+dv
hdl/crtc_pkg.sv
hdl/crtc_regs.sv
hdl/crtc_sync_gen.sv
hdl/crtc_top.sv
dv/crtc_tb.sv
